/* hdl/cache_settings.svh */
// ----------------------------
// Cache sizing macros shared by the cache package and RTL
// ----------------------------

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define CACHE_ADDR_W  32  // Byte address
`define CACHE_DATA_W  32  // Processor word
`define CACHE_LINE_W  128 // Memory side moves whole lines

`define CACHE_NBYTES  256
`define CACHE_NLINES  (`CACHE_NBYTES * 8 / `CACHE_LINE_W)

// Address split, 4 offset bits for a 16-byte line
`define CACHE_IDX_W   4
`define CACHE_TAG_W   (`CACHE_ADDR_W - `CACHE_IDX_W - 4)

`define CACHE_OPQ_W   8

`endif

/* hdl/cache_pkg.sv */
// ----------------------------
// Cache message types, request codes and address decode
// ----------------------------

`include "cache_settings.svh"

package cache_pkg;

  typedef enum logic [2:0] {
    mem_rd = 3'd0,
    mem_wr = 3'd1
  } mem_type_e;

  // Address seen as a word or as tag/index/offset fields
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [1:0]              word_off;
    logic [1:0]              byte_off;
  } cache_addr_fields_t;

  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] word;
    cache_addr_fields_t       f;
  } cache_addr_u;

  // ----------------------------
  // Processor side messages
  // ----------------------------

  typedef struct packed {
    mem_type_e                type_;
    logic [`CACHE_OPQ_W-1:0]  opaque;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [1:0]               len;     // Always zero, full words only
    logic [`CACHE_DATA_W-1:0] data;
  } cache_req_msg_t;

  typedef struct packed {
    mem_type_e                type_;
    logic [`CACHE_OPQ_W-1:0]  opaque;
    logic [1:0]               len;
    logic [`CACHE_DATA_W-1:0] data;
  } cache_resp_msg_t;

  // ----------------------------
  // Memory side messages
  // ----------------------------

  typedef struct packed {
    mem_type_e                type_;
    logic [`CACHE_OPQ_W-1:0]  opaque;
    logic [`CACHE_ADDR_W-1:0] addr;    // Line aligned
    logic [3:0]               len;
    logic [`CACHE_LINE_W-1:0] data;
  } mem_req_msg_t;

  typedef struct packed {
    mem_type_e                type_;
    logic [`CACHE_OPQ_W-1:0]  opaque;
    logic [3:0]               len;
    logic [`CACHE_LINE_W-1:0] data;
  } mem_resp_msg_t;

  // Control unit to datapath
  typedef struct packed {
    logic                       tag_array_ren;
    logic                       tag_array_wen;
    logic                       data_array_ren;
    logic                       data_array_wen;
    logic [`CACHE_LINE_W/8-1:0] data_array_wben;
    logic                       evict_addr_reg_en;
    logic                       read_data_reg_en;
    logic                       write_data_mux_sel;  // 1 selects the refill line
    logic                       memreq_addr_mux_sel; // 1 selects the request line
    logic [1:0]                 read_word_mux_sel;
    mem_type_e                  memreq_type;
    mem_type_e                  cacheresp_type;
  } dpath_ctrl_t;

  // Datapath to control unit
  typedef struct packed {
    logic                    tag_match;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [1:0]              word_off;
    mem_type_e               req_type;
  } dpath_stat_t;

endpackage

/* hdl/cache_sram.sv */
// ----------------------------
// Single port array, byte masked write, combinational read
// ----------------------------

`timescale 1ns/1ps

module cache_sram #(
  parameter int width = 128,
  parameter int depth = 16,
  localparam int addr_w = $clog2(depth),
  localparam int nbytes = (width + 7) / 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              read_en,
  input  logic [addr_w-1:0] read_addr,
  output logic [width-1:0]  read_data,
  input  logic              write_en,
  input  logic [nbytes-1:0] write_byte_en,
  input  logic [addr_w-1:0] write_addr,
  input  logic [width-1:0]  write_data
);

  logic [width-1:0] mem [depth];

  assign read_data = read_en ? mem[read_addr] : '0;

  // No writes land while reset is held
  always_ff @(posedge clk) begin
    if (write_en && !rst) begin
      for (int i = 0; i < nbytes; i++) begin
        if (write_byte_en[i])
          mem[write_addr][i*8 +: 8] <= write_data[i*8 +: 8];
      end
    end
  end

endmodule

/* hdl/cache_dpath.sv */
// ----------------------------
// Cache datapath: request and refill registers, arrays,
// tag compare, eviction address and message packing
// ----------------------------

`timescale 1ns/1ps

`include "cache_settings.svh"

module cache_dpath
  import cache_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            cachereq_en,
  input  cache_req_msg_t  cachereq_msg,
  input  logic            memresp_en,
  input  mem_resp_msg_t   memresp_msg,
  input  dpath_ctrl_t     ctrl,
  output dpath_stat_t     stat,
  output cache_resp_msg_t cacheresp_msg,
  output mem_req_msg_t    memreq_msg
);

  // ----------------------------
  // Request and refill registers
  // ----------------------------

  cache_addr_u              req_addr;
  mem_type_e                req_type;
  logic [`CACHE_OPQ_W-1:0]  req_opaque;
  logic [`CACHE_DATA_W-1:0] req_data;
  logic [`CACHE_LINE_W-1:0] refill_line;

  always_ff @(posedge clk) begin
    if (rst)
      req_type <= mem_rd;
    else if (cachereq_en)
      req_type <= cachereq_msg.type_;
  end

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      req_addr.word <= cachereq_msg.addr;
      req_opaque    <= cachereq_msg.opaque;
      req_data      <= cachereq_msg.data;
    end
  end

  always_ff @(posedge clk) begin
    if (memresp_en)
      refill_line <= memresp_msg.data;
  end

  // Store word copied into every slot, byte enables pick the slot
  logic [`CACHE_LINE_W-1:0] write_line;

  assign write_line = ctrl.write_data_mux_sel ? refill_line : {4{req_data}};

  // ----------------------------
  // Tag and data arrays
  // ----------------------------

  logic [`CACHE_TAG_W-1:0]  read_tag;
  logic [`CACHE_LINE_W-1:0] array_line;

  cache_sram #(
    .width (`CACHE_TAG_W),
    .depth (`CACHE_NLINES)
  ) tag_array (
    .clk           (clk),
    .rst           (rst),
    .read_en       (ctrl.tag_array_ren),
    .read_addr     (req_addr.f.idx),
    .read_data     (read_tag),
    .write_en      (ctrl.tag_array_wen),
    .write_byte_en ('1),
    .write_addr    (req_addr.f.idx),
    .write_data    (req_addr.f.tag)
  );

  cache_sram #(
    .width (`CACHE_LINE_W),
    .depth (`CACHE_NLINES)
  ) data_array (
    .clk           (clk),
    .rst           (rst),
    .read_en       (ctrl.data_array_ren),
    .read_addr     (req_addr.f.idx),
    .read_data     (array_line),
    .write_en      (ctrl.data_array_wen),
    .write_byte_en (ctrl.data_array_wben),
    .write_addr    (req_addr.f.idx),
    .write_data    (write_line)
  );

  assign stat.tag_match = (read_tag == req_addr.f.tag);
  assign stat.idx       = req_addr.f.idx;
  assign stat.word_off  = req_addr.f.word_off;
  assign stat.req_type  = req_type;

  // ----------------------------
  // Line addresses
  // ----------------------------

  cache_addr_u              fill_addr;  // Line of the current request
  cache_addr_u              evict_next; // Line now resident at this index
  logic [`CACHE_ADDR_W-1:0] evict_addr;

  always_comb begin
    fill_addr.f.tag      = req_addr.f.tag;
    fill_addr.f.idx      = req_addr.f.idx;
    fill_addr.f.word_off = 2'b00;
    fill_addr.f.byte_off = 2'b00;
  end

  always_comb begin
    evict_next.f.tag      = read_tag;
    evict_next.f.idx      = req_addr.f.idx;
    evict_next.f.word_off = 2'b00;
    evict_next.f.byte_off = 2'b00;
  end

  always_ff @(posedge clk) begin
    if (rst)
      evict_addr <= '0;
    else if (ctrl.evict_addr_reg_en)
      evict_addr <= evict_next.word;
  end

  // ----------------------------
  // Read register and response
  // ----------------------------

  logic [`CACHE_LINE_W-1:0] read_line;
  logic [`CACHE_DATA_W-1:0] read_word;

  always_ff @(posedge clk) begin
    if (ctrl.read_data_reg_en)
      read_line <= array_line;
  end

  assign read_word = read_line[ctrl.read_word_mux_sel*`CACHE_DATA_W +: `CACHE_DATA_W];

  always_comb begin
    cacheresp_msg.type_  = ctrl.cacheresp_type;
    cacheresp_msg.opaque = req_opaque;    // Echo back to the processor
    cacheresp_msg.len    = '0;
    cacheresp_msg.data   = (ctrl.cacheresp_type == mem_wr) ? '0 : read_word;
  end

  // Write-back carries the line latched during evict-prepare
  always_comb begin
    memreq_msg.type_  = ctrl.memreq_type;
    memreq_msg.opaque = '0;
    memreq_msg.addr   = ctrl.memreq_addr_mux_sel ? fill_addr.word : evict_addr;
    memreq_msg.len    = '0;
    memreq_msg.data   = read_line;
  end

endmodule

/* hdl/cache_ctrl.sv */
// ----------------------------
// Cache control: FSM, valid and dirty bits, datapath strobes
// ----------------------------

`timescale 1ns/1ps

`include "cache_settings.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cachereq_val,
  input  logic        memresp_val,
  input  dpath_stat_t stat,
  output dpath_ctrl_t ctrl,
  output logic        busy,
  output logic        cacheresp_val,
  output logic        memreq_val
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_evict_prep,
    st_wb_req,
    st_wb_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update,
    st_access,
    st_respond
  } state_e;

  state_e state;
  state_e state_next;

  logic [`CACHE_NLINES-1:0] valid;
  logic [`CACHE_NLINES-1:0] dirty;
  logic                     hit;
  logic                     line_dirty;

  assign hit        = valid[stat.idx] && stat.tag_match;
  assign line_dirty = valid[stat.idx] && dirty[stat.idx];

  // ----------------------------
  // State register and line bits
  // ----------------------------

  always_ff @(posedge clk) begin
    if (rst)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (state == st_refill_update) begin
        valid[stat.idx] <= 1'b1;
        dirty[stat.idx] <= 1'b0; // Fresh line matches memory
      end
      if (state == st_access && stat.req_type == mem_wr)
        dirty[stat.idx] <= 1'b1;
    end
  end

  // ----------------------------
  // Next state
  // ----------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle:          if (cachereq_val) state_next = st_tag_check;
      st_tag_check: begin
        if (hit)
          state_next = st_access;
        else if (line_dirty)
          state_next = st_evict_prep;
        else
          state_next = st_refill_req;
      end
      st_evict_prep:    state_next = st_wb_req;
      st_wb_req:        state_next = st_wb_wait;
      st_wb_wait:       if (memresp_val) state_next = st_refill_req;
      st_refill_req:    state_next = st_refill_wait;
      st_refill_wait:   if (memresp_val) state_next = st_refill_update;
      st_refill_update: state_next = st_access;
      st_access:        state_next = st_respond;
      st_respond:       state_next = st_idle;
      default:          state_next = st_idle;
    endcase
  end

  // ----------------------------
  // Datapath controls
  // ----------------------------

  always_comb begin
    ctrl                   = '0;
    ctrl.memreq_type       = mem_rd;
    ctrl.cacheresp_type    = stat.req_type;
    ctrl.read_word_mux_sel = stat.word_off;
    case (state)
      st_tag_check: ctrl.tag_array_ren = 1'b1;
      st_evict_prep: begin
        // Old tag forms the eviction address, old line goes to the read register
        ctrl.tag_array_ren     = 1'b1;
        ctrl.data_array_ren    = 1'b1;
        ctrl.evict_addr_reg_en = 1'b1;
        ctrl.read_data_reg_en  = 1'b1;
      end
      st_wb_req: begin
        ctrl.memreq_type         = mem_wr;
        ctrl.memreq_addr_mux_sel = 1'b0;
      end
      st_refill_req: ctrl.memreq_addr_mux_sel = 1'b1;
      st_refill_update: begin
        ctrl.tag_array_wen      = 1'b1;
        ctrl.data_array_wen     = 1'b1;
        ctrl.data_array_wben    = '1;   // Whole line
        ctrl.write_data_mux_sel = 1'b1;
      end
      st_access: begin
        if (stat.req_type == mem_wr) begin
          ctrl.data_array_wen  = 1'b1;
          ctrl.data_array_wben = 16'h000f << {stat.word_off, 2'b00};
        end else begin
          ctrl.data_array_ren   = 1'b1;
          ctrl.read_data_reg_en = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign busy          = (state != st_idle);
  assign cacheresp_val = (state == st_respond);
  assign memreq_val    = (state == st_wb_req) || (state == st_refill_req);

endmodule

/* hdl/blocking_cache.sv */
// ----------------------------
// Blocking write-back data cache, control unit plus datapath
// ----------------------------

`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic            clk,
  input  logic            rst,

  // Processor side
  input  logic            cachereq_val,
  input  cache_req_msg_t  cachereq_msg,
  output logic            busy,
  output logic            cacheresp_val,
  output cache_resp_msg_t cacheresp_msg,

  // Memory side
  output logic            memreq_val,
  output mem_req_msg_t    memreq_msg,
  input  logic            memresp_val,
  input  mem_resp_msg_t   memresp_msg
);

  dpath_ctrl_t ctrl;
  dpath_stat_t stat;

  cache_ctrl i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cachereq_val  (cachereq_val),
    .memresp_val   (memresp_val),
    .stat          (stat),
    .ctrl          (ctrl),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .memreq_val    (memreq_val)
  );

  // Strobes double as capture enables for the datapath registers
  cache_dpath i_dpath (
    .clk           (clk),
    .rst           (rst),
    .cachereq_en   (cachereq_val),
    .cachereq_msg  (cachereq_msg),
    .memresp_en    (memresp_val),
    .memresp_msg   (memresp_msg),
    .ctrl          (ctrl),
    .stat          (stat),
    .cacheresp_msg (cacheresp_msg),
    .memreq_msg    (memreq_msg)
  );

endmodule

/* test/tb_clock.sv */
// ------------------------------
// Free running testbench clock
// ------------------------------

`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period_ns / 2) clk = ~clk;

endmodule

/* test/tb_blocking_cache.sv */
// ------------------------------
// Testbench for the blocking cache with a line memory model,
// reference model, directed and random requests
// ------------------------------

`timescale 1ns/1ps

`include "cache_settings.svh"

module tb_blocking_cache
  import cache_pkg::*;
;

  localparam int idle_limit = 50;   // Cycles
  localparam int resp_limit = 200;

  logic            clk;
  logic            rst;
  logic            cachereq_val;
  cache_req_msg_t  cachereq_msg;
  logic            busy;
  logic            cacheresp_val;
  cache_resp_msg_t cacheresp_msg;
  logic            memreq_val;
  mem_req_msg_t    memreq_msg;
  logic            memresp_val;
  mem_resp_msg_t   memresp_msg;

  integer seed = 32'h0ad6_7834;
  string  test_name = "reset";

  logic [31:0] backing [1024]; // 4 KB behind the cache
  logic [31:0] shadow [1024];  // What the processor should see

  // Reference copy of the tag state
  logic [`CACHE_TAG_W-1:0]  ref_tag [`CACHE_NLINES];
  logic [`CACHE_NLINES-1:0] ref_valid;
  logic [`CACHE_NLINES-1:0] ref_dirty;

  cache_resp_msg_t resp_q [$];
  mem_req_msg_t    memreq_q [$];

  tb_clock #(.period_ns (40)) i_clock (.clk (clk));

  blocking_cache i_dut (
    .clk           (clk),
    .rst           (rst),
    .cachereq_val  (cachereq_val),
    .cachereq_msg  (cachereq_msg),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_msg (cacheresp_msg),
    .memreq_val    (memreq_val),
    .memreq_msg    (memreq_msg),
    .memresp_val   (memresp_val),
    .memresp_msg   (memresp_msg)
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic logic [31:0] init_word(input int w);
    logic [31:0] a;
    a = w;
    return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f; // Odd multiplier spreads every address bit
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    return shadow[addr[11:2]];
  endfunction

  function automatic logic [`CACHE_LINE_W-1:0] ref_line(input logic [31:0] line_addr);
    logic [`CACHE_LINE_W-1:0] line;
    for (int i = 0; i < 4; i++)
      line[i*32 +: 32] = shadow[{line_addr[11:4], i[1:0]}];
    return line;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Miss traffic for a direct-mapped write-back, write-allocate cache
  task automatic predict_line_traffic(input mem_type_e typ, input logic [31:0] addr);
    logic [3:0]   idx;
    logic [23:0]  tag;
    logic [31:0]  old_line;
    mem_req_msg_t wb;
    mem_req_msg_t rd;
    idx = addr[7:4];
    tag = addr[31:8];
    if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
      if (ref_valid[idx] && ref_dirty[idx]) begin
        old_line    = {ref_tag[idx], idx, 4'h0};
        wb.type_    = mem_wr;
        wb.opaque   = '0;
        wb.addr     = old_line;
        wb.len      = '0;
        wb.data     = ref_line(old_line);
        memreq_q.push_back(wb);
      end
      rd.type_       = mem_rd;
      rd.opaque      = '0;
      rd.addr        = {tag, idx, 4'h0};
      rd.len         = '0;
      rd.data        = '0;
      memreq_q.push_back(rd);
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
      ref_dirty[idx] = 1'b0;
    end
    if (typ == mem_wr)
      ref_dirty[idx] = 1'b1;
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_resp(input string name, input cache_resp_msg_t exp,
                            input cache_resp_msg_t act);
    if (act !== exp)
      stop_on_error($sformatf(
        "Mismatch in %s: expected type=%0d opaque=%h data=%h, actual type=%0d opaque=%h data=%h",
        name, exp.type_, exp.opaque, exp.data, act.type_, act.opaque, act.data));
  endtask

  task automatic check_memreq(input string name, input mem_req_msg_t exp,
                              input mem_req_msg_t act);
    logic same;
    same = (act.type_ === exp.type_) && (act.addr === exp.addr) &&
           (act.opaque === exp.opaque) && (act.len === exp.len);
    if (exp.type_ == mem_wr)
      same = same && (act.data === exp.data); // Refill requests carry no data
    if (!same)
      stop_on_error($sformatf(
        "Mismatch in %s: expected memreq type=%0d addr=%h data=%h, actual type=%0d addr=%h data=%h",
        name, exp.type_, exp.addr, exp.data, act.type_, act.addr, act.data));
  endtask

  always @(negedge clk) begin : compare
    cache_resp_msg_t exp_resp;
    mem_req_msg_t    exp_memreq;
    if (cacheresp_val) begin
      if (resp_q.size() == 0)
        stop_on_error("The cache answered with no request outstanding");
      exp_resp = resp_q.pop_front();
      check_resp(test_name, exp_resp, cacheresp_msg);
    end
    if (memreq_val) begin
      if (memreq_q.size() == 0)
        stop_on_error($sformatf("Unexpected memory request to %h in %s",
                                memreq_msg.addr, test_name));
      exp_memreq = memreq_q.pop_front();
      check_memreq(test_name, exp_memreq, memreq_msg);
    end
  end

  // ------------------------------
  // Memory model
  // ------------------------------

  initial begin : memory_model
    mem_req_msg_t             req;
    logic [`CACHE_LINE_W-1:0] line;
    int                       delay;
    memresp_val = 1'b0;
    memresp_msg = '0;
    for (int w = 0; w < 1024; w++)
      backing[w] = init_word(w);
    forever begin
      @(negedge clk);
      memresp_val = 1'b0;
      if (memreq_val) begin
        req = memreq_msg;
        for (int i = 0; i < 4; i++) begin
          if (req.type_ == mem_wr)
            backing[{req.addr[11:4], i[1:0]}] = req.data[i*32 +: 32];
          line[i*32 +: 32] = backing[{req.addr[11:4], i[1:0]}];
        end
        delay = 1 + ({$random(seed)} % 4);
        repeat (delay) @(negedge clk);
        memresp_msg.type_  = req.type_;
        memresp_msg.opaque = req.opaque;
        memresp_msg.len    = '0;
        memresp_msg.data   = (req.type_ == mem_rd) ? line : '0;
        memresp_val        = 1'b1;          // One cycle pulse
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic send_request(input string name, input mem_type_e typ,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [7:0] opq, output int latency);
    cache_resp_msg_t exp;
    int              cycles;
    cycles = 0;
    while (busy !== 1'b0) begin
      if (cycles == idle_limit)
        stop_on_error("The cache stayed busy before a new request");
      @(negedge clk);
      cycles++;
    end
    test_name = name;
    predict_line_traffic(typ, addr);
    exp.type_  = typ;
    exp.opaque = opq;
    exp.len    = '0;
    exp.data   = (typ == mem_wr) ? '0 : ref_read(addr);
    resp_q.push_back(exp);
    if (typ == mem_wr)
      shadow[addr[11:2]] = data;
    cachereq_msg.type_  = typ;
    cachereq_msg.opaque = opq;
    cachereq_msg.addr   = addr;
    cachereq_msg.len    = '0;
    cachereq_msg.data   = data;
    cachereq_val        = 1'b1;
    @(negedge clk);
    cachereq_val = 1'b0;
    latency      = 1;
    while (cacheresp_val !== 1'b1) begin
      if (busy !== 1'b1)
        stop_on_error($sformatf("busy was low while the request in %s was in flight", name));
      if (latency == resp_limit)
        stop_on_error($sformatf("No response from the cache for %h in %s", addr, name));
      @(negedge clk);
      latency++;
    end
    @(negedge clk);
    if (busy !== 1'b0)
      stop_on_error($sformatf("busy stayed high after the response in %s", name));
    if (memreq_q.size() != 0)
      stop_on_error($sformatf("A predicted memory request was never sent in %s", name));
  endtask

  initial begin
    int          lat;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    mem_type_e   r_type;
    rst          = 1'b1;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    ref_valid    = '0;
    ref_dirty    = '0;
    for (int i = 0; i < `CACHE_NLINES; i++)
      ref_tag[i] = '0;
    for (int w = 0; w < 1024; w++)
      shadow[w] = init_word(w);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Cold read goes to memory for the aligned line
    send_request("cold_read", mem_rd, 32'h0000_0124, 32'h0, 8'h5a, lat);

    // Same line again is a hit with fixed latency
    send_request("hit_timing", mem_rd, 32'h0000_0128, 32'h0, 8'h3c, lat);
    if (lat != 3)
      stop_on_error($sformatf("Mismatch in hit_timing: expected latency 3, actual %0d", lat));

    // Write hit, then every word of the line
    send_request("write_hit", mem_wr, 32'h0000_012c, 32'hdead_beef, 8'h11, lat);
    for (int i = 0; i < 4; i++)
      send_request("write_hit", mem_rd, 32'h0000_0120 + 4 * i, 32'h0, 8'h20 + 8'(i), lat);

    // Conflicting read pushes the dirty line out first
    send_request("dirty_evict", mem_rd, 32'h0000_0220, 32'h0, 8'h77, lat);

    for (int n = 0; n < 300; n++) begin
      r_addr = {$random(seed)} & 32'h0000_03fc;   // Word aligned within 1 KB
      r_type = ($random(seed) & 1) ? mem_wr : mem_rd;
      r_data = $random(seed);
      send_request("random_mix", r_type, r_addr, r_data, n[7:0], lat);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_sram.sv
hdl/cache_dpath.sv
hdl/cache_ctrl.sv
hdl/blocking_cache.sv
test/tb_clock.sv
test/tb_blocking_cache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_blocking_cache
FILELIST  = files.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
